// ==== run.sh ====
#!/bin/sh
# Build the DMA testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f src.f --top-module tb_periph_dma -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" sim.log; then
  echo "Failure reported in sim.log"
  exit 1
fi

if ! grep -q "Test passed" sim.log; then
  echo "No pass line in sim.log"
  exit 1
fi

exit 0

// ==== src.f ====
+incdir+src
src/wb_pkg.sv
src/dma_pkg.sv
src/dma_regs.sv
src/dma_engine.sv
src/wb_port_arbiter.sv
src/periph_dma_top.sv
verif/periph_dma_checker.sv
verif/tb_periph_dma.sv

// ==== src/dma_engine.sv ====
// Word copy FSM driving a Wishbone classic master
`timescale 1ns/1ps
`include "periph_dma_consts.svh"

module dma_engine (
  input  logic               periph_clk,
  input  logic               rst_n_i,
  input  dma_pkg::dma_desc_t desc_i,
  input  logic               start_i,
  output logic               busy_o,
  output logic               finish_o,
  output wb_pkg::wb_req_t    bus_req_o,
  input  wb_pkg::wb_rsp_t    bus_rsp_i
);

  dma_pkg::dma_state_e     state_q;
  dma_pkg::dma_desc_t      desc_q;
  logic                    req_q;    // cyc/stb of the current bus cycle
  logic [`PDMA_ADDR_W-1:0] ofs_q;
  logic [`PDMA_ADDR_W-1:0] ofs_next;
  logic [`PDMA_ADDR_W-1:0] len_bytes;
  logic [`PDMA_DATA_W-1:0] data_q;
  logic                    bus_done;
  logic                    is_write;
  logic                    zero_len;

  assign bus_done  = req_q & bus_rsp_i.ack;
  assign ofs_next  = ofs_q + `PDMA_ADDR_W'(4);
  assign len_bytes = {desc_q.len[`PDMA_ADDR_W-1:2], 2'b00};  // Whole words only
  assign zero_len  = (desc_i.len[`PDMA_ADDR_W-1:2] == '0);
  assign is_write  = (state_q == dma_pkg::WRITE);

  //////////////////////////////
  // State machine
  //////////////////////////////

  always_ff @(posedge periph_clk) begin
    if (!rst_n_i) begin
      state_q <= dma_pkg::IDLE;
      req_q   <= 1'b0;
      ofs_q   <= '0;
    end else begin
      case (state_q)
        dma_pkg::IDLE: begin
          if (start_i) begin
            ofs_q <= '0;
            if (zero_len) begin
              state_q <= dma_pkg::DONE;  // Nothing to move
            end else begin
              state_q <= dma_pkg::READ;
              req_q   <= 1'b1;
            end
          end
        end
        dma_pkg::READ: begin
          if (bus_done) begin
            state_q <= dma_pkg::WRITE;
            req_q   <= 1'b0;
          end else if (!req_q) begin
            req_q <= 1'b1;
          end
        end
        dma_pkg::WRITE: begin
          if (bus_done) begin
            req_q <= 1'b0;
            ofs_q <= ofs_next;
            if (ofs_next >= len_bytes) begin
              state_q <= dma_pkg::DONE;
            end else begin
              state_q <= dma_pkg::READ;
            end
          end else if (!req_q) begin
            req_q <= 1'b1;
          end
        end
        default: state_q <= dma_pkg::IDLE;  // DONE lasts one cycle
      endcase
    end
  end

  // Descriptor and read word
  always_ff @(posedge periph_clk) begin
    if (start_i && state_q == dma_pkg::IDLE) begin
      desc_q <= desc_i;
    end
    if (bus_done && !is_write) begin
      data_q <= bus_rsp_i.dat;
    end
  end

  //////////////////////////////
  // Bus request
  //////////////////////////////

  // Gap of one idle cycle after every ack lets the arbiter hand over
  always_comb begin
    bus_req_o.cyc = req_q;
    bus_req_o.stb = req_q;
    bus_req_o.we  = is_write;
    bus_req_o.adr = is_write ? desc_q.dst + ofs_q : desc_q.src + ofs_q;
    bus_req_o.dat = data_q;
    bus_req_o.sel = '1;
  end

  assign busy_o   = (state_q != dma_pkg::IDLE);
  assign finish_o = (state_q == dma_pkg::DONE);

endmodule

// ==== src/dma_pkg.sv ====
// Register offset and engine state enums, descriptor and status structs
`include "periph_dma_consts.svh"

package dma_pkg;

  //////////////////////////////
  // Register map
  //////////////////////////////

  typedef enum logic [7:0] {
    REG_SRC    = `PDMA_OFS_SRC,
    REG_DST    = `PDMA_OFS_DST,
    REG_LEN    = `PDMA_OFS_LEN,
    REG_CTRL   = `PDMA_OFS_CTRL,
    REG_STATUS = `PDMA_OFS_STATUS
  } reg_ofs_e;

  //////////////////////////////
  // Copy engine
  //////////////////////////////

  typedef enum logic [1:0] {
    IDLE,
    READ,   // Fetch one word from src
    WRITE,  // Store it at dst
    DONE
  } dma_state_e;

  // Transfer descriptor, len in bytes
  typedef struct packed {
    logic [`PDMA_ADDR_W-1:0] src;
    logic [`PDMA_ADDR_W-1:0] dst;
    logic [`PDMA_ADDR_W-1:0] len;
  } dma_desc_t;

  // Bit 1 done, bit 0 busy
  typedef struct packed {
    logic done;
    logic busy;
  } dma_status_t;

endpackage

// ==== src/dma_regs.sv ====
// Wishbone slave register file: descriptor, start pulse, status and interrupt
`timescale 1ns/1ps
`include "periph_dma_consts.svh"

module dma_regs (
  input  logic               periph_clk,
  input  logic               rst_n_i,
  input  wb_pkg::wb_req_t    cfg_req_i,
  output wb_pkg::wb_rsp_t    cfg_rsp_o,
  input  logic               busy_i,
  input  logic               finish_i,
  output dma_pkg::dma_desc_t desc_o,
  output logic               start_o,
  output logic               irq_o
);

  logic                    ack_q;
  logic [`PDMA_DATA_W-1:0] rdata_q;
  logic                    start_q;
  logic                    done_q;
  dma_pkg::dma_desc_t      desc_q;
  dma_pkg::dma_status_t    status;
  dma_pkg::reg_ofs_e       ofs;
  logic                    access;
  logic                    wr;
  logic                    idle;

  // Byte lane merge for partial writes
  function automatic logic [`PDMA_DATA_W-1:0] merge_sel(
    input logic [`PDMA_DATA_W-1:0] old_v,
    input logic [`PDMA_DATA_W-1:0] new_v,
    input logic [`PDMA_SEL_W-1:0]  sel
  );
    logic [`PDMA_DATA_W-1:0] res;
    res = old_v;
    for (int b = 0; b < `PDMA_SEL_W; b++) begin
      if (sel[b]) res[8*b +: 8] = new_v[8*b +: 8];
    end
    return res;
  endfunction

  assign access = cfg_req_i.cyc & cfg_req_i.stb & ~ack_q; // One access per ack
  assign wr     = access & cfg_req_i.we;
  assign ofs    = dma_pkg::reg_ofs_e'(cfg_req_i.adr[7:0]);
  assign idle   = ~busy_i & ~start_q;  // Start cycle counts as busy

  assign status.busy = busy_i;
  assign status.done = done_q;

  //////////////////////////////
  // Control and status
  //////////////////////////////

  always_ff @(posedge periph_clk) begin
    if (!rst_n_i) begin
      ack_q   <= 1'b0;
      start_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      ack_q   <= access;
      start_q <= wr && (ofs == dma_pkg::REG_CTRL) && cfg_req_i.sel[0] &&
                 cfg_req_i.dat[0] && idle;
      if (start_q) begin
        done_q <= 1'b0;
      end else if (finish_i) begin
        done_q <= 1'b1;  // Sticky until next start
      end
    end
  end

  //////////////////////////////
  // Descriptor and read data
  //////////////////////////////

  always_ff @(posedge periph_clk) begin
    if (wr && idle) begin
      case (ofs)
        dma_pkg::REG_SRC: desc_q.src <= merge_sel(desc_q.src, cfg_req_i.dat, cfg_req_i.sel);
        dma_pkg::REG_DST: desc_q.dst <= merge_sel(desc_q.dst, cfg_req_i.dat, cfg_req_i.sel);
        dma_pkg::REG_LEN: desc_q.len <= merge_sel(desc_q.len, cfg_req_i.dat, cfg_req_i.sel);
        default: ;
      endcase
    end
    if (access) begin
      case (ofs)
        dma_pkg::REG_SRC:    rdata_q <= desc_q.src;
        dma_pkg::REG_DST:    rdata_q <= desc_q.dst;
        dma_pkg::REG_LEN:    rdata_q <= desc_q.len;
        dma_pkg::REG_STATUS: rdata_q <= {{(`PDMA_DATA_W-2){1'b0}}, status};
        default:             rdata_q <= '0;  // CTRL and holes
      endcase
    end
  end

  assign cfg_rsp_o.ack = ack_q;
  assign cfg_rsp_o.dat = rdata_q;
  assign desc_o        = desc_q;
  assign start_o       = start_q;
  assign irq_o         = done_q;

endmodule

// ==== src/periph_dma_consts.svh ====
// Bus widths, external master count and register byte offsets
`ifndef PERIPH_DMA_CONSTS_SVH
`define PERIPH_DMA_CONSTS_SVH

//////////////////////////////
// Wishbone bus geometry
//////////////////////////////

`define PDMA_ADDR_W 32
`define PDMA_DATA_W 32
`define PDMA_SEL_W  4

// Masters sharing the memory port besides the engine
`define PDMA_NUM_EXT 2

//////////////////////////////
// Register map
//////////////////////////////

`define PDMA_OFS_SRC    8'h00
`define PDMA_OFS_DST    8'h04
`define PDMA_OFS_LEN    8'h08
`define PDMA_OFS_CTRL   8'h0C
`define PDMA_OFS_STATUS 8'h10

`endif

// ==== src/periph_dma_top.sv ====
// DMA subsystem top: register file, copy engine and memory port arbiter
`timescale 1ns/1ps
`include "periph_dma_consts.svh"

module periph_dma_top (
  input  logic                                  periph_clk,
  input  logic                                  rst_n_i,
  input  wb_pkg::wb_req_t                       cfg_req_i,
  output wb_pkg::wb_rsp_t                       cfg_rsp_o,
  input  wb_pkg::wb_req_t [`PDMA_NUM_EXT-1:0]   ext_req_i,
  output wb_pkg::wb_rsp_t [`PDMA_NUM_EXT-1:0]   ext_rsp_o,
  output wb_pkg::wb_req_t                       mem_req_o,
  input  wb_pkg::wb_rsp_t                       mem_rsp_i,
  output logic                                  irq_o
);

  dma_pkg::dma_desc_t                 desc;
  logic                               start;
  logic                               busy;
  logic                               finish;
  wb_pkg::wb_req_t                    eng_req;
  wb_pkg::wb_rsp_t                    eng_rsp;
  wb_pkg::wb_req_t [`PDMA_NUM_EXT:0]  arb_req;
  wb_pkg::wb_rsp_t [`PDMA_NUM_EXT:0]  arb_rsp;

  // Engine on port 0
  assign arb_req   = {ext_req_i, eng_req};
  assign eng_rsp   = arb_rsp[0];
  assign ext_rsp_o = arb_rsp[`PDMA_NUM_EXT:1];

  dma_regs u_regs (
    .periph_clk ( periph_clk ),
    .rst_n_i    ( rst_n_i    ),
    .cfg_req_i  ( cfg_req_i  ),
    .cfg_rsp_o  ( cfg_rsp_o  ),
    .busy_i     ( busy       ),
    .finish_i   ( finish     ),
    .desc_o     ( desc       ),
    .start_o    ( start      ),
    .irq_o      ( irq_o      )
  );

  dma_engine u_engine (
    .periph_clk ( periph_clk ),
    .rst_n_i    ( rst_n_i    ),
    .desc_i     ( desc       ),
    .start_i    ( start      ),
    .busy_o     ( busy       ),
    .finish_o   ( finish     ),
    .bus_req_o  ( eng_req    ),
    .bus_rsp_i  ( eng_rsp    )
  );

  wb_port_arbiter #(
    .num_masters_p ( `PDMA_NUM_EXT + 1 )
  ) u_arbiter (
    .periph_clk ( periph_clk ),
    .rst_n_i    ( rst_n_i    ),
    .req_i      ( arb_req    ),
    .rsp_o      ( arb_rsp    ),
    .req_o      ( mem_req_o  ),
    .rsp_i      ( mem_rsp_i  )
  );

endmodule

// ==== src/wb_pkg.sv ====
// Wishbone classic request and response structs, arbiter grant vector
`include "periph_dma_consts.svh"

package wb_pkg;

  //////////////////////////////
  // Bus channels
  //////////////////////////////

  // Master to slave
  typedef struct packed {
    logic                    cyc;
    logic                    stb;
    logic                    we;
    logic [`PDMA_ADDR_W-1:0] adr;
    logic [`PDMA_DATA_W-1:0] dat;
    logic [`PDMA_SEL_W-1:0]  sel;
  } wb_req_t;

  // Slave to master
  typedef struct packed {
    logic                    ack;
    logic [`PDMA_DATA_W-1:0] dat;
  } wb_rsp_t;

  // One bit per arbiter port, engine on bit 0
  typedef logic [`PDMA_NUM_EXT:0] grant_t;

endpackage

// ==== src/wb_port_arbiter.sv ====
// Round-robin Wishbone arbiter with registered grant, many masters to one slave
`timescale 1ns/1ps

module wb_port_arbiter #(
  parameter int unsigned num_masters_p = 3
) (
  input  logic                                  periph_clk,
  input  logic                                  rst_n_i,
  input  wb_pkg::wb_req_t [num_masters_p-1:0]   req_i,
  output wb_pkg::wb_rsp_t [num_masters_p-1:0]   rsp_o,
  output wb_pkg::wb_req_t                       req_o,
  input  wb_pkg::wb_rsp_t                       rsp_i
);

  localparam int unsigned idx_w_lp = $clog2(num_masters_p);

  logic [num_masters_p-1:0] grant_q;
  logic [num_masters_p-1:0] grant_d;
  logic [num_masters_p-1:0] cyc_vec;
  logic [idx_w_lp-1:0]      last_q;   // Last holder, lowest priority next round
  logic [idx_w_lp-1:0]      last_d;
  logic                     hold;

  always_comb begin
    for (int i = 0; i < num_masters_p; i++) begin
      cyc_vec[i] = req_i[i].cyc;
    end
  end

  assign hold = |(grant_q & cyc_vec);

  //////////////////////////////
  // Grant selection
  //////////////////////////////

  always_comb begin
    int  idx;
    logic found;
    grant_d = grant_q;
    last_d  = last_q;
    found   = 1'b0;
    idx     = 0;
    if (!hold) begin
      grant_d = '0;
      // Search starts one past the last holder
      for (int i = 1; i <= num_masters_p; i++) begin
        idx = int'(last_q) + i;
        if (idx >= int'(num_masters_p)) idx = idx - int'(num_masters_p);
        if (!found && cyc_vec[idx]) begin
          found        = 1'b1;
          grant_d[idx] = 1'b1;
          last_d       = idx_w_lp'(idx);
        end
      end
    end
  end

  always_ff @(posedge periph_clk) begin
    if (!rst_n_i) begin
      grant_q <= '0;
      last_q  <= idx_w_lp'(num_masters_p - 1);  // Port 0 wins first
    end else begin
      grant_q <= grant_d;
      last_q  <= last_d;
    end
  end

  //////////////////////////////
  // Request and response paths
  //////////////////////////////

  always_comb begin
    req_o = '0;
    for (int i = 0; i < num_masters_p; i++) begin
      if (grant_q[i]) req_o = req_i[i];
    end
  end

  always_comb begin
    for (int i = 0; i < num_masters_p; i++) begin
      rsp_o[i].ack = rsp_i.ack & grant_q[i];  // Ack only to the holder
      rsp_o[i].dat = rsp_i.dat;
    end
  end

endmodule

// ==== verif/periph_dma_checker.sv ====
// Bound assertions on ack exclusivity, memory request stability, reset irq and arbiter fairness
`timescale 1ns/1ps
`include "periph_dma_consts.svh"

module periph_dma_checker (
  input logic                                 periph_clk,
  input logic                                 rst_n_i,
  input wb_pkg::wb_req_t [`PDMA_NUM_EXT:0]    arb_req_i,
  input wb_pkg::wb_rsp_t [`PDMA_NUM_EXT:0]    arb_rsp_i,
  input wb_pkg::wb_req_t                      mem_req_i,
  input wb_pkg::wb_rsp_t                      mem_rsp_i,
  input logic                                 irq_i
);

  localparam int unsigned num_masters_lp = `PDMA_NUM_EXT + 1;

  wb_pkg::grant_t            ack_vec;
  logic [num_masters_lp-1:0] cyc_vec;
  int unsigned               wait_cnt [num_masters_lp];

  always_comb begin
    for (int i = 0; i < num_masters_lp; i++) begin
      ack_vec[i] = arb_rsp_i[i].ack;
      cyc_vec[i] = arb_req_i[i].cyc;
    end
  end

  // Acks seen by other masters while a port waits
  always_ff @(posedge periph_clk) begin
    for (int i = 0; i < num_masters_lp; i++) begin
      if (!rst_n_i || !cyc_vec[i] || ack_vec[i]) begin
        wait_cnt[i] <= 0;
      end else if (|ack_vec) begin
        wait_cnt[i] <= wait_cnt[i] + 1;
      end
    end
  end

  one_ack_a: assert property (@(posedge periph_clk) disable iff (!rst_n_i) $onehot0(ack_vec))
    else $error("more than one master acked in a cycle");

  mem_stable_a: assert property (@(posedge periph_clk) disable iff (!rst_n_i)
    (mem_req_i.cyc && mem_req_i.stb && !mem_rsp_i.ack) |=> $stable(mem_req_i))
    else $error("memory request changed before ack");

  irq_reset_a: assert property (@(posedge periph_clk) !rst_n_i |=> !irq_i)
    else $error("irq high during reset");

  for (genvar g = 0; g < num_masters_lp; g++) begin : g_fair
    fair_a: assert property (@(posedge periph_clk) disable iff (!rst_n_i)
      wait_cnt[g] <= num_masters_lp)
      else $error("port starved by the arbiter");
  end

endmodule

bind periph_dma_top periph_dma_checker u_checker (
  .periph_clk ( periph_clk ),
  .rst_n_i    ( rst_n_i    ),
  .arb_req_i  ( arb_req    ),
  .arb_rsp_i  ( arb_rsp    ),
  .mem_req_i  ( mem_req_o  ),
  .mem_rsp_i  ( mem_rsp_i  ),
  .irq_i      ( irq_o      )
);

// ==== verif/tb_periph_dma.sv ====
// Testbench with clock, reset, memory model, bus tasks, copy tests, timeout and summary
`timescale 1ns/1ps
`include "periph_dma_consts.svh"

module tb_periph_dma;

  // Longest test moves 16 words at well under 100 cycles each
  localparam int MAX_CYCLES = 20000;

  logic                                 periph_clk;
  logic                                 rst_n_i;
  wb_pkg::wb_req_t                      cfg_req;
  wb_pkg::wb_rsp_t                      cfg_rsp;
  wb_pkg::wb_req_t [`PDMA_NUM_EXT-1:0]  ext_req;
  wb_pkg::wb_rsp_t [`PDMA_NUM_EXT-1:0]  ext_rsp;
  wb_pkg::wb_req_t                      mem_req;
  wb_pkg::wb_rsp_t                      mem_rsp;
  logic                                 irq;

  logic [31:0]     mem [256];
  integer          seed = 78804;
  int              errors = 0;
  int              tests_run = 0;
  int              tests_failed = 0;
  int              cycles = 0;
  int              mem_acks = 0;
  logic [1:0]      wait_left;
  logic [31:0]     rd;

  periph_dma_top DUT (
    .periph_clk ( periph_clk ),
    .rst_n_i    ( rst_n_i    ),
    .cfg_req_i  ( cfg_req    ),
    .cfg_rsp_o  ( cfg_rsp    ),
    .ext_req_i  ( ext_req    ),
    .ext_rsp_o  ( ext_rsp    ),
    .mem_req_o  ( mem_req    ),
    .mem_rsp_i  ( mem_rsp    ),
    .irq_o      ( irq        )
  );

  initial begin
    periph_clk = 1'b0;
    forever #10 periph_clk = ~periph_clk;
  end

  ////////////////////////////////
  // Memory model with 0 to 3 wait states
  ////////////////////////////////

  always @(negedge periph_clk) begin
    if (mem_rsp.ack) begin
      mem_rsp.ack = 1'b0;
      wait_left   = 2'($random(seed));
    end else if (mem_req.cyc && mem_req.stb) begin
      if (wait_left == 0) begin
        if (mem_req.we) mem[mem_req.adr[9:2]] = mem_req.dat;
        mem_rsp.dat = mem[mem_req.adr[9:2]];
        mem_rsp.ack = 1'b1;
        mem_acks++;
      end else begin
        wait_left = wait_left - 1;
      end
    end
  end

  always @(posedge periph_clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, DMA or bus never completed", cycles);
      $display("Test failed");
      $finish;
    end
  end

  ////////////////////////////////
  // Bus tasks
  ////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic cfg_access(input logic we, input logic [7:0] ofs, input logic [31:0] wdat,
                            output logic [31:0] rdat);
    @(negedge periph_clk);
    cfg_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: 32'(ofs), dat: wdat, sel: 4'hF};
    do @(negedge periph_clk); while (!cfg_rsp.ack);
    rdat = cfg_rsp.dat;
    @(negedge periph_clk);
    cfg_req = '0;
  endtask

  task automatic cfg_write(input logic [7:0] ofs, input logic [31:0] wdat);
    logic [31:0] unused;
    cfg_access(1'b1, ofs, wdat, unused);
  endtask

  task automatic cfg_read(input logic [7:0] ofs, output logic [31:0] rdat);
    cfg_access(1'b0, ofs, 32'h0, rdat);
  endtask

  task automatic ext_access(input int p, input logic we, input logic [31:0] adr,
                            input logic [31:0] wdat, output logic [31:0] rdat);
    @(negedge periph_clk);
    ext_req[p] = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat, sel: 4'hF};
    do @(posedge periph_clk); while (!ext_rsp[p].ack);
    rdat = ext_rsp[p].dat;
    @(negedge periph_clk);
    ext_req[p] = '0;
  endtask

  task automatic ext_write(input int p, input logic [31:0] adr, input logic [31:0] wdat);
    logic [31:0] unused;
    ext_access(p, 1'b1, adr, wdat, unused);
  endtask

  task automatic ext_read(input int p, input logic [31:0] adr, output logic [31:0] rdat);
    ext_access(p, 1'b0, adr, 32'h0, rdat);
  endtask

  // Writes then reads back a private block through one external port
  task automatic ext_traffic(input int p, input logic [31:0] base);
    logic [31:0] got;
    for (int k = 0; k < 4; k++) ext_write(p, base + 4 * k, {8'(p), 8'hE0, 16'(k)});
    for (int k = 0; k < 4; k++) begin
      ext_read(p, base + 4 * k, got);
      check_value($sformatf("ext%0d_rdata", p), got, {8'(p), 8'hE0, 16'(k)});
    end
  endtask

  task automatic start_copy(input logic [31:0] src, input logic [31:0] dst, input logic [31:0] len);
    cfg_write(`PDMA_OFS_SRC, src);
    cfg_write(`PDMA_OFS_DST, dst);
    cfg_write(`PDMA_OFS_LEN, len);
    cfg_write(`PDMA_OFS_CTRL, 32'h1);
  endtask

  task automatic wait_irq();
    while (!irq) @(negedge periph_clk);
  endtask

  task automatic fill_random(input int first, input int count);
    for (int k = 0; k < count; k++) mem[first + k] = $random(seed);
  endtask

  task automatic compare_block(input string name, input int src_w, input int dst_w, input int n);
    for (int k = 0; k < n; k++) begin
      check_value($sformatf("%s[%0d]", name, k), mem[dst_w + k], mem[src_w + k]);
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (errors != errs_before) tests_failed++;
    $display("%-28s %s", name, (errors == errs_before) ? "ok" : "FAILED");
  endtask

  ////////////////////////////////
  // Tests
  ////////////////////////////////

  initial begin
    int e0;
    int acks0;
    rst_n_i = 1'b0;
    cfg_req = '0;
    ext_req = '0;
    mem_rsp = '0;
    wait_left = 2'd0;
    for (int a = 0; a < 256; a++) mem[a] = {24'hA5A5_00, 8'(a)} ^ (32'(a) << 20);
    repeat (8) @(negedge periph_clk);
    rst_n_i = 1'b1;

    e0 = errors;
    check_value("irq_o", 32'(irq), 32'h0);
    check_value("mem_req_o.cyc", 32'(mem_req.cyc), 32'h0);
    cfg_write(`PDMA_OFS_SRC, 32'h1234_5678);
    cfg_write(`PDMA_OFS_DST, 32'h0BAD_F00C);
    cfg_write(`PDMA_OFS_LEN, 32'h0000_0100);
    cfg_read(`PDMA_OFS_SRC, rd);
    check_value("src", rd, 32'h1234_5678);
    cfg_read(`PDMA_OFS_DST, rd);
    check_value("dst", rd, 32'h0BAD_F00C);
    cfg_read(`PDMA_OFS_LEN, rd);
    check_value("len", rd, 32'h0000_0100);
    cfg_read(`PDMA_OFS_STATUS, rd);
    check_value("status", rd, 32'h0);
    end_test("reset and register access", e0);

    e0 = errors;
    fill_random(0, 16);
    start_copy(32'h000, 32'h100, 32'd64);
    wait_irq();
    cfg_read(`PDMA_OFS_STATUS, rd);
    check_value("status", rd, 32'h2);  // done set and busy clear
    check_value("irq_o", 32'(irq), 32'h1);
    compare_block("copy16", 0, 64, 16);
    end_test("16 word copy", e0);

    e0 = errors;
    fill_random(128, 8);
    mem[200] = 32'h5E47_1E00;
    acks0 = mem_acks;
    start_copy(32'h200, 32'h300, 32'd32);
    cfg_read(`PDMA_OFS_STATUS, rd);
    check_value("status.busy", rd & 32'h1, 32'h1);
    cfg_write(`PDMA_OFS_SRC, 32'h040);
    cfg_write(`PDMA_OFS_LEN, 32'h100);
    cfg_write(`PDMA_OFS_CTRL, 32'h1);
    wait_irq();
    check_value("mem_acks", 32'(mem_acks - acks0), 32'd16);  // 8 reads and 8 writes
    cfg_read(`PDMA_OFS_SRC, rd);
    check_value("src", rd, 32'h200);
    cfg_read(`PDMA_OFS_LEN, rd);
    check_value("len", rd, 32'd32);
    compare_block("copy8", 128, 192, 8);
    check_value("mem[200]", mem[200], 32'h5E47_1E00);
    end_test("writes ignored while busy", e0);

    e0 = errors;
    acks0 = mem_acks;
    start_copy(32'h000, 32'h100, 32'd0);
    wait_irq();
    check_value("mem_acks", 32'(mem_acks), 32'(acks0));
    cfg_read(`PDMA_OFS_STATUS, rd);
    check_value("status", rd, 32'h2);
    end_test("zero length", e0);

    e0 = errors;
    fill_random(32, 16);
    start_copy(32'h080, 32'h180, 32'd64);
    fork
      ext_traffic(0, 32'h280);
      ext_traffic(1, 32'h2C0);
    join
    wait_irq();
    compare_block("copy_shared", 32, 96, 16);
    end_test("external masters during copy", e0);

    $display("Summary: %0d tests, %0d passed, %0d failed, %0d check errors",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
